// File: logic/axil_regs.sv
`timescale 1ns/1ps

module axil_regs import fir_pkg::*; #(
	parameter int tm = 8,
	parameter int dsp_nr = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [axi_addr_width-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input word_t S_AXI_WDATA,
	input logic [3:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [axi_addr_width-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output word_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	output word_t switches,
	coef_wr_if.source coef_wr
);
	waddr_t awaddr_q;
	waddr_t araddr_q;
	logic aw_en;
	logic reg_wren;
	logic reg_rden;
	logic [tap_field_width-1:0] tap_field;
	word_t reg_data_out;

	// every response is OKAY
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	// accept address and data together, only while idle
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			aw_en <= 1'b1;
		end else if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en) begin
			S_AXI_AWREADY <= 1'b1;
			S_AXI_WREADY <= 1'b1;
			aw_en <= 1'b0;
		end else begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			// idle again once the response is taken
			if (S_AXI_BREADY && S_AXI_BVALID)
				aw_en <= 1'b1;
		end
	end

	// word address held through the handshake cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en)
			awaddr_q <= S_AXI_AWADDR[axi_addr_width-1:addr_lsb];
	end

	assign reg_wren = S_AXI_AWREADY && S_AXI_WREADY && S_AXI_AWVALID && S_AXI_WVALID;
	// upper field picks the tap, lower field the bank entry
	assign tap_field = awaddr_q[bank_addr_width +: tap_field_width];

	// write response, held until bready
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_BVALID <= 1'b0;
		else if (reg_wren && !S_AXI_BVALID)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BREADY && S_AXI_BVALID)
			S_AXI_BVALID <= 1'b0;
	end

	// write decode: coefficient strobe or switches
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			switches <= '0;
			coef_wr.wr_en <= 1'b0;
		end else begin
			coef_wr.wr_en <= 1'b0;
			if (reg_wren) begin
				if (tap_field >= tap_field_width'(coef_base))
					coef_wr.wr_en <= 1'b1;
				else if (awaddr_q == reg_switches)
					switches <= S_AXI_WDATA;
			end
		end
	end

	// coefficient payload, goes out with the strobe
	always_ff @(posedge S_AXI_ACLK) begin
		if (reg_wren) begin
			coef_wr.tap_sel <= tap_field - tap_field_width'(coef_base);
			coef_wr.phase <= awaddr_q[bank_addr_width-1:0];
			// sign from bit 31, magnitude bits from the bottom
			coef_wr.coef <= {S_AXI_WDATA[axi_data_width-1], S_AXI_WDATA[coef_width-2:0]};
		end
	end

	// read address, one cycle arready pulse
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_ARREADY <= 1'b0;
		end else if (!S_AXI_ARREADY && S_AXI_ARVALID) begin
			S_AXI_ARREADY <= 1'b1;
			araddr_q <= S_AXI_ARADDR[axi_addr_width-1:addr_lsb];
		end else begin
			S_AXI_ARREADY <= 1'b0;
		end
	end

	assign reg_rden = S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_RVALID <= 1'b0;
		else if (reg_rden)
			S_AXI_RVALID <= 1'b1;
		else if (S_AXI_RVALID && S_AXI_RREADY)
			S_AXI_RVALID <= 1'b0;
	end

	// read map, unmapped words give zero
	always_comb begin
		case (araddr_q)
			reg_name: reg_data_out = prog_name;
			reg_version: reg_data_out = prog_version;
			reg_coefs_nr: reg_data_out = word_t'(tm * dsp_nr);
			reg_tm: reg_data_out = word_t'(tm);
			reg_dsp_nr: reg_data_out = word_t'(dsp_nr);
			reg_coef_mag: reg_data_out = word_t'(coef_mag);
			reg_coef_base: reg_data_out = word_t'(coef_base);
			reg_switches: reg_data_out = switches;
			default: reg_data_out = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (reg_rden)
			S_AXI_RDATA <= reg_data_out;
	end
endmodule

// File: logic/coef_wr_if.sv
`timescale 1ns/1ps

interface coef_wr_if import fir_pkg::*; ();
	// one cycle write strobe
	logic wr_en;
	// tap number, already offset by coef_base
	logic [tap_field_width-1:0] tap_sel;
	// entry within the tap's bank
	logic [bank_addr_width-1:0] phase;
	coef_t coef;

	modport source (
		output wr_en, tap_sel, phase, coef
	);
	modport sink (
		input wr_en, tap_sel, phase, coef
	);
endinterface

// File: logic/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
	parameter int depth = 1,
	parameter type payload_t = logic [7:0]
) (
	input logic S_AXI_ACLK,
	input payload_t din,
	output payload_t dout
);
	payload_t stage [depth];

	// plain shift chain, first stage takes din
	always_ff @(posedge S_AXI_ACLK) begin
		stage[0] <= din;
		for (int i = 1; i < depth; i++)
			stage[i] <= stage[i-1];
	end

	// oldest stage out
	assign dout = stage[depth-1];
endmodule

// File: logic/fir_axi_top.sv
`timescale 1ns/1ps

module fir_axi_top import fir_pkg::*; #(
	parameter int tm = 8,
	parameter int dsp_nr = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [axi_addr_width-1:0] S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input word_t S_AXI_WDATA,
	input logic [3:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input logic [axi_addr_width-1:0] S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output word_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input sample_t fir_in,
	output sample_t fir_out,
	output logic [7:0] leds
);
	word_t switches;

	// coefficient path from register block to taps
	coef_wr_if coef_wr ();

	axil_regs #(.tm(tm), .dsp_nr(dsp_nr)) u_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WSTRB(S_AXI_WSTRB),
		.S_AXI_WVALID(S_AXI_WVALID),
		.S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP),
		.S_AXI_BVALID(S_AXI_BVALID),
		.S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA),
		.S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY),
		.switches(switches),
		.coef_wr(coef_wr.source)
	);

	// low switch byte shown on the leds
	assign leds = switches[7:0];

	fir_engine #(.tm(tm), .dsp_nr(dsp_nr)) u_engine (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.fir_en(switches[sw_fir_en]),
		.fir_in(fir_in),
		.fir_out(fir_out),
		.coef_wr(coef_wr.sink)
	);
endmodule

// File: logic/fir_engine.sv
`timescale 1ns/1ps

module fir_engine import fir_pkg::*; #(
	parameter int tm = 8,
	parameter int dsp_nr = 4
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic fir_en,
	input sample_t fir_in,
	output sample_t fir_out,
	coef_wr_if.sink coef_wr
);
	localparam int phase_width = $clog2(tm);

	logic [phase_width-1:0] phase;
	logic period_end;
	sample_t x_reg;
	sample_t x_chain [dsp_nr+1];
	acc_t sum_chain [dsp_nr+1];
	sample_t filt_q;

	// phase counter, one sample period is tm cycles
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			phase <= '0;
		else if (period_end)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	assign period_end = (phase == phase_width'(tm - 1));

	// input sample register, reloads at phase 0 and holds otherwise
	delay_line #(.depth(1), .payload_t(sample_t)) u_in (
		.S_AXI_ACLK(S_AXI_ACLK),
		.din((phase == '0) ? fir_in : x_reg),
		.dout(x_reg)
	);

	assign x_chain[0] = x_reg;
	// chain starts from zero
	assign sum_chain[0] = '0;

	// tap k covers coefficients k*tm up to k*tm+tm-1
	for (genvar k = 0; k < dsp_nr; k++) begin : g_tap
		fir_tap #(.tm(tm), .index(k)) u_tap (
			.S_AXI_ACLK(S_AXI_ACLK),
			.phase(phase),
			.period_end(period_end),
			.x_in(x_chain[k]),
			.x_out(x_chain[k+1]),
			.sum_in(sum_chain[k]),
			.sum_out(sum_chain[k+1]),
			.coef_wr(coef_wr)
		);
	end

	// last stage holds the full sum during phase dsp_nr
	// drop the coefficient fraction, keep sample width
	always_ff @(posedge S_AXI_ACLK) begin
		if (phase == phase_width'(dsp_nr))
			filt_q <= sum_chain[dsp_nr][coef_mag+sample_width-1:coef_mag];
	end

	// bypass while the filter is off
	assign fir_out = fir_en ? filt_q : fir_in;
endmodule

// File: logic/fir_pkg.sv
package fir_pkg;
	// bus geometry
	localparam int axi_data_width = 32;
	localparam int axi_addr_width = 16;
	localparam int addr_lsb = 2;
	// word address split into tap field and phase field
	localparam int bank_addr_width = 7;
	localparam int tap_field_width = 7;
	// datapath widths
	localparam int sample_width = 14;
	localparam int coef_width = 18;
	localparam int coef_mag = 17;
	localparam int acc_width = 32;
	typedef logic signed [sample_width-1:0] sample_t;
	typedef logic signed [coef_width-1:0] coef_t;
	typedef logic signed [acc_width-1:0] acc_t;
	typedef logic [axi_data_width-1:0] word_t;
	typedef logic [axi_addr_width-addr_lsb-1:0] waddr_t;
	// tap field value that selects tap 0
	localparam int coef_base = 1;
	// register word indices
	localparam waddr_t reg_name = 0;
	localparam waddr_t reg_version = 1;
	localparam waddr_t reg_coefs_nr = 4;
	localparam waddr_t reg_tm = 8;
	localparam waddr_t reg_dsp_nr = 9;
	localparam waddr_t reg_coef_mag = 12;
	localparam waddr_t reg_coef_base = 16;
	localparam waddr_t reg_switches = 20;
	// switch bit for filter enable
	localparam int sw_fir_en = 1;
	// ascii id words, byte order reversed so a byte dump reads forward
	localparam word_t prog_name = " RIF";
	localparam word_t prog_version = " 0.1";
endpackage

// File: logic/fir_tap.sv
`timescale 1ns/1ps

module fir_tap import fir_pkg::*; #(
	parameter int tm = 8,
	parameter int index = 0
) (
	input logic S_AXI_ACLK,
	input logic [$clog2(tm)-1:0] phase,
	input logic period_end,
	input sample_t x_in,
	output sample_t x_out,
	input acc_t sum_in,
	output acc_t sum_out,
	coef_wr_if.sink coef_wr
);
	localparam int phase_width = $clog2(tm);

	coef_t bank [tm];
	sample_t hist [tm];
	acc_t prod;
	acc_t acc;
	acc_t acc_next;
	acc_t total;

	// bank write, only for this tap and an entry in range
	always_ff @(posedge S_AXI_ACLK) begin
		if (coef_wr.wr_en && coef_wr.tap_sel == tap_field_width'(index)
				&& coef_wr.phase < bank_addr_width'(tm))
			bank[coef_wr.phase[phase_width-1:0]] <= coef_wr.coef;
	end

	// history moves one sample per period, oldest goes on to the next tap
	always_ff @(posedge S_AXI_ACLK) begin
		if (period_end) begin
			hist[0] <= x_in;
			for (int i = 1; i < tm; i++)
				hist[i] <= hist[i-1];
		end
	end
	assign x_out = hist[tm-1];

	// one product per cycle, restart at phase 0
	assign prod = hist[phase] * bank[phase];
	assign acc_next = ((phase == '0) ? acc_t'(0) : acc) + prod;

	always_ff @(posedge S_AXI_ACLK) begin
		acc <= acc_next;
	end

	// period total held for a full period so the chain can pick it up at phase index
	delay_line #(.depth(1), .payload_t(acc_t)) u_total (
		.S_AXI_ACLK(S_AXI_ACLK),
		.din(period_end ? acc_next : total),
		.dout(total)
	);

	// systolic sum stage
	always_ff @(posedge S_AXI_ACLK) begin
		sum_out <= sum_in + total;
	end
endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the FIR testbench with Verilator
# the run counts as failed when the log holds the fail message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fir_axi \
	-f vlog.f -Mdir obj_dir -o tb_fir_axi > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_fir_axi > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q 'Test failures found' sim.log; then
	exit 1
fi
exit 0

// File: sim/tb_fir_axi.sv
`timescale 1ns/1ps

module tb_fir_axi import fir_pkg::*; ();
	localparam int tm = 8;
	localparam int dsp_nr = 4;
	localparam int n_coefs = tm * dsp_nr;
	localparam int clk_ns = 4;
	// history spans n_coefs samples of tm cycles, wait three times that
	localparam int settle_cycles = 3 * n_coefs * tm;
	localparam int coef_writes = 2 * n_coefs + 1;
	localparam int watchdog_cycles = 2 * (coef_writes * 10 + 3 * settle_cycles);
	localparam int hs_limit = 32;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [axi_addr_width-1:0] awaddr;
	logic [axi_addr_width-1:0] araddr;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	word_t wdata;
	word_t rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	sample_t fir_in;
	sample_t fir_out;
	logic [7:0] leds;
	int errors;
	int checks;
	int seed;
	// model of the coefficient banks, tap k phase p at k*tm+p
	int coefs [n_coefs];

	fir_axi_top #(.tm(tm), .dsp_nr(dsp_nr)) dut0 (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid),
		.S_AXI_WREADY(wready), .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid),
		.S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready), .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready),
		.fir_in(fir_in), .fir_out(fir_out), .leds(leds)
	);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #(clk_ns / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected 0x%08h, actual 0x%08h", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	function automatic logic [axi_addr_width-1:0] word_addr(input int word);
		return axi_addr_width'(word << addr_lsb);
	endfunction

	// tap field above the phase field, tap 0 sits at coef_base
	function automatic logic [axi_addr_width-1:0] coef_addr(input int k, input int p);
		return word_addr(((k + coef_base) << bank_addr_width) | p);
	endfunction

	task automatic axil_write(input logic [axi_addr_width-1:0] addr, input word_t data);
		int n;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while (!(awready && wready) && n < hs_limit) begin
			next_cycle();
			n++;
		end
		if (!(awready && wready)) begin
			errors++;
			$display("write to 0x%04h was never accepted", addr);
		end
		// valids stay up through the handshake edge
		next_cycle();
		awvalid = 1'b0;
		wvalid = 1'b0;
		n = 0;
		while (!bvalid && n < hs_limit) begin
			next_cycle();
			n++;
		end
		if (!bvalid) begin
			errors++;
			$display("write to 0x%04h got no response", addr);
		end else begin
			check_word("write bresp", '0, word_t'(bresp));
		end
		next_cycle();
	endtask

	task automatic axil_read(input logic [axi_addr_width-1:0] addr, output word_t data);
		int n;
		araddr = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < hs_limit) begin
			next_cycle();
			n++;
		end
		if (!arready) begin
			errors++;
			$display("read of 0x%04h was never accepted", addr);
		end
		next_cycle();
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < hs_limit) begin
			next_cycle();
			n++;
		end
		if (!rvalid) begin
			errors++;
			$display("read of 0x%04h returned no data", addr);
		end else begin
			check_word("read rresp", '0, word_t'(rresp));
		end
		data = rdata;
		next_cycle();
	endtask

	// bit 31 carries the sign, low bits the rest
	task automatic load_coef(input int k, input int p, input int c);
		coefs[k * tm + p] = c;
		axil_write(coef_addr(k, p), word_t'(c));
	endtask

	// floor of x times coefficient sum over 2^coef_mag, low sample bits
	function automatic sample_t expected_out(input int x);
		longint total;
		longint prod;
		total = 0;
		for (int i = 0; i < n_coefs; i++)
			total += coefs[i];
		prod = longint'(x) * total;
		return sample_t'(prod >>> coef_mag);
	endfunction

	task automatic wait_settle();
		repeat (settle_cycles) next_cycle();
	endtask

	task automatic read_ident();
		word_t v;
		axil_read(word_addr(0), v);
		check_word("ident name", prog_name, v);
		axil_read(word_addr(1), v);
		check_word("ident version", prog_version, v);
		axil_read(word_addr(4), v);
		check_word("ident coef count", 32'd32, v);
		axil_read(word_addr(8), v);
		check_word("ident tm", 32'd8, v);
		axil_read(word_addr(9), v);
		check_word("ident dsp_nr", 32'd4, v);
		axil_read(word_addr(12), v);
		check_word("ident coef_mag", 32'd17, v);
		axil_read(word_addr(16), v);
		check_word("ident coef_base", 32'd1, v);
		// hole in the map
		axil_read(word_addr(3), v);
		check_word("unmapped word", '0, v);
	endtask

	task automatic switches_readback();
		word_t v;
		axil_write(word_addr(20), 32'h0000_00a5);
		axil_read(word_addr(20), v);
		check_word("switches readback", 32'h0000_00a5, v);
		check_word("leds", 32'h0000_00a5, word_t'(leds));
	endtask

	// filter still off from the switches value
	task automatic bypass_follow();
		sample_t x;
		repeat (6) begin
			x = sample_t'($random(seed));
			fir_in = x;
			#1;
			check_sample("bypass", x, fir_out);
			next_cycle();
		end
	endtask

	task automatic const_response();
		fir_in = 14'sd1000;
		for (int k = 0; k < dsp_nr; k++)
			for (int p = 0; p < tm; p++)
				load_coef(k, p, 1024);
		axil_write(word_addr(20), word_t'(1 << sw_fir_en));
		wait_settle();
		check_sample("constant input", expected_out(1000), fir_out);
	endtask

	task automatic random_response();
		int k;
		int p;
		fir_in = -14'sd500;
		for (int i = 0; i < dsp_nr; i++)
			for (int j = 0; j < tm; j++)
				load_coef(i, j, $random(seed) % 2001);
		wait_settle();
		check_sample("random coefs", expected_out(-500), fir_out);
		// one bank entry changed in place
		k = $unsigned($random(seed)) % dsp_nr;
		p = $unsigned($random(seed)) % tm;
		load_coef(k, p, -1999);
		wait_settle();
		check_sample("rewritten coef", expected_out(-500), fir_out);
	endtask

	initial begin
		#(watchdog_cycles * clk_ns);
		$display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

	initial begin
		seed = 8;
		errors = 0;
		checks = 0;
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		fir_in = '0;
		repeat (8) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		next_cycle();
		read_ident();
		switches_readback();
		bypass_follow();
		const_response();
		random_response();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end
endmodule

// File: vlog.f
logic/fir_pkg.sv
logic/coef_wr_if.sv
logic/delay_line.sv
logic/axil_regs.sv
logic/fir_tap.sv
logic/fir_engine.sv
logic/fir_axi_top.sv
sim/tb_fir_axi.sv
